//--- dcache_top.f
hdl/dcache_pkg.sv
hdl/dcache_beat_counter.sv
hdl/dcache_data_array.sv
hdl/dcache_tag_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tb/dcache_tb_mem.sv
tb/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module dcache_tb \
    -f dcache_top.f -o dcache_sim

./obj_dir/dcache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

//--- tb/dcache_tb.sv
/*
 * Testbench for the 2-way data cache. Applies a table of CPU accesses to
 * the top level, next to a memory model with random back-pressure, and
 * checks read data, hit timing and the memory traffic of every access.
 */
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    typedef struct packed {
        logic       write;
        addr_t      addr;
        word_t      wdata;
        logic       exp_hit;
        logic       exp_wb;                    // dirty victim goes out first
        line_addr_t wb_line;
    } row_t;

    localparam index_t SET_R = 8'h11;          // plain hit tests
    localparam index_t SET_S = 8'h3c;          // eviction tests
    localparam tag_t   TAG_T = 20'h00123;
    localparam tag_t   TAG_A = 20'h0000a;
    localparam tag_t   TAG_B = 20'h0000b;
    localparam tag_t   TAG_C = 20'h0000c;
    localparam tag_t   TAG_D = 20'h0000d;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        cpu_valid;
    logic        cpu_ready;
    logic        cpu_write;
    addr_t       cpu_addr;
    word_t       cpu_wdata;
    logic        rsp_valid;
    word_t       rsp_rdata;
    logic        mem_req_valid;
    logic        mem_req_ready;
    mem_op_e     mem_req_op;
    line_addr_t  mem_req_addr;
    logic        mem_wvalid;
    logic        mem_wready;
    word_t       mem_wdata;
    logic        mem_rvalid;
    word_t       mem_rdata;

    string       names [$];
    row_t        rows [$];
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;
    int          i;

    always #10 clk = ~clk;

    dcache_top UUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .cpu_valid     (cpu_valid),
        .cpu_ready     (cpu_ready),
        .cpu_write     (cpu_write),
        .cpu_addr      (cpu_addr),
        .cpu_wdata     (cpu_wdata),
        .rsp_valid     (rsp_valid),
        .rsp_rdata     (rsp_rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_op    (mem_req_op),
        .mem_req_addr  (mem_req_addr),
        .mem_wvalid    (mem_wvalid),
        .mem_wready    (mem_wready),
        .mem_wdata     (mem_wdata),
        .mem_rvalid    (mem_rvalid),
        .mem_rdata     (mem_rdata)
    );

    dcache_tb_mem mem_model (
        .clk           (clk),
        .arst_n        (arst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_op    (mem_req_op),
        .mem_req_addr  (mem_req_addr),
        .mem_wvalid    (mem_wvalid),
        .mem_wready    (mem_wready),
        .mem_wdata     (mem_wdata),
        .mem_rvalid    (mem_rvalid),
        .mem_rdata     (mem_rdata)
    );

    ////////////////////////////////////////////////////////////
    // failure reporting and typed compares
    ////////////////////////////////////////////////////////////
    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            fail_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_line_addr(string name, line_addr_t exp, line_addr_t act);
        if (act !== exp) begin
            fail_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            fail_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            fail_run($sformatf("timeout: no result after %0d cycles, controller stuck in %s",
                               cycle_count, UUT.u_ctrl.state_q.name()));
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////
    function automatic addr_t make_addr(tag_t t, index_t x, offset_t o);
        return {t, x, o};
    endfunction

    task automatic add_row(string name, logic wr, addr_t a, word_t d, logic hit,
                           logic wb, line_addr_t wb_line);
        names.push_back(name);
        rows.push_back('{write: wr, addr: a, wdata: d, exp_hit: hit, exp_wb: wb,
                         wb_line: wb_line});
    endtask

    task automatic build_table();
        add_row("rd_miss",        0, make_addr(TAG_T, SET_R, 1), 0, 0, 0, '0);
        add_row("rd_hit_line",    0, make_addr(TAG_T, SET_R, 3), 0, 1, 0, '0);
        add_row("wr_hit",         1, make_addr(TAG_T, SET_R, 2), 32'hcafe_0001, 1, 0, '0);
        add_row("rd_after_wr",    0, make_addr(TAG_T, SET_R, 2), 0, 1, 0, '0);
        add_row("wr_miss_a",      1, make_addr(TAG_A, SET_S, 1), 32'h1234_5678, 0, 0, '0);
        add_row("rd_miss_b",      0, make_addr(TAG_B, SET_S, 0), 0, 0, 0, '0);
        add_row("touch_a",        0, make_addr(TAG_A, SET_S, 1), 0, 1, 0, '0);
        add_row("rd_c_evict_b",   0, make_addr(TAG_C, SET_S, 2), 0, 0, 0, '0);
        add_row("rd_d_evict_a",   0, make_addr(TAG_D, SET_S, 3), 0, 0, 1, {TAG_A, SET_S});
        add_row("rd_a_again",     0, make_addr(TAG_A, SET_S, 1), 0, 0, 0, '0);
        add_row("rd_hit_d",       0, make_addr(TAG_D, SET_S, 0), 0, 1, 0, '0);
        add_row("wr_hit_word0",   1, make_addr(TAG_T, SET_R, 0), 32'h0bad_f00d, 1, 0, '0);
        add_row("rd_word0",       0, make_addr(TAG_T, SET_R, 0), 0, 1, 0, '0);
        add_row("rd_c_evict_a",   0, make_addr(TAG_C, SET_S, 2), 0, 0, 0, '0);
    endtask

    task automatic run_row(int n);
        row_t        r;
        string       name;
        int unsigned reads_before;
        int unsigned writes_before;
        int unsigned wait_cycles;
        int          b;
        r             = rows[n];
        name          = names[n];
        reads_before  = mem_model.num_reads;
        writes_before = mem_model.num_writes;
        @(posedge clk);
        #1;
        cpu_valid = 1'b1;
        cpu_write = r.write;
        cpu_addr  = r.addr;
        cpu_wdata = r.wdata;
        @(negedge clk);
        while (!cpu_ready) begin
            @(negedge clk);
        end
        @(posedge clk);                          // request taken here
        #1;
        cpu_valid = 1'b0;
        if (r.write) begin
            mem_model.note_cpu_write(r.addr, r.wdata);
        end
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (!rsp_valid);
        check_flag({name, " hit"}, r.exp_hit, wait_cycles == 1);
        if (!r.write) begin
            check_word({name, " read data"}, mem_model.expected_word(r.addr), rsp_rdata);
        end
        if (r.exp_hit) begin
            check_flag({name, " no fill"}, 1'b1, mem_model.num_reads == reads_before);
        end else begin
            check_flag({name, " one fill"}, 1'b1, mem_model.num_reads == reads_before + 1);
            check_line_addr({name, " fill line"}, r.addr[ADDR_W-1:OFFSET_W],
                            mem_model.last_read_line);
        end
        if (r.exp_wb) begin
            check_flag({name, " one write-back"}, 1'b1,
                       mem_model.num_writes == writes_before + 1);
            check_line_addr({name, " write-back line"}, r.wb_line, mem_model.last_write_line);
            for (b = 0; b < WORDS_PER_LINE; b++) begin
                check_word($sformatf("%s beat %0d", name, b),
                           mem_model.expected_word({r.wb_line, offset_t'(b)}),
                           mem_model.wb_beats[b]);
            end
        end else begin
            check_flag({name, " no write-back"}, 1'b1, mem_model.num_writes == writes_before);
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        cpu_valid = 1'b0;
        cpu_write = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        build_table();
        cycle_limit = rows.size() * 60;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_flag("reset cpu_ready", 1'b1, cpu_ready);
        check_flag("reset rsp_valid", 1'b0, rsp_valid);
        check_flag("reset mem_req_valid", 1'b0, mem_req_valid);
        check_flag("reset mem_wvalid", 1'b0, mem_wvalid);
        for (i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/dcache_tb_mem.sv
/*
 * Memory model for the data cache testbench. Serves line reads and takes
 * write-backs with random ready and refill gaps, and keeps a shadow of the
 * CPU-visible words that the testbench uses for expected values.
 */
`default_nettype none

module dcache_tb_mem (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         mem_req_valid,
    output logic                        mem_req_ready,
    input  wire dcache_pkg::mem_op_e    mem_req_op,
    input  wire dcache_pkg::line_addr_t mem_req_addr,
    input  wire                         mem_wvalid,
    output logic                        mem_wready,
    input  wire dcache_pkg::word_t      mem_wdata,
    output logic                        mem_rvalid,
    output dcache_pkg::word_t           mem_rdata
);
    import dcache_pkg::*;

    localparam word_t FILL_KEY = 32'h5a3c_96e1;

    word_t       store [addr_t];               // written-back words only
    word_t       shadow [addr_t];              // cpu writes as they happen
    word_t       wb_beats [WORDS_PER_LINE];    // last write-back, in beat order
    logic [31:0] lfsr;
    line_addr_t  rd_line;
    line_addr_t  wr_line;
    line_addr_t  last_read_line;
    line_addr_t  last_write_line;
    int unsigned rd_count;
    int unsigned wr_count;
    int unsigned num_reads;
    int unsigned num_writes;
    logic        rd_busy;
    logic        wr_busy;

    function automatic word_t init_word(addr_t a);
        return {2'b00, a} ^ FILL_KEY;
    endfunction

    function automatic word_t backing_word(addr_t a);
        return store.exists(a) ? store[a] : init_word(a);
    endfunction

    function automatic word_t expected_word(addr_t a);
        return shadow.exists(a) ? shadow[a] : init_word(a);
    endfunction

    task automatic note_cpu_write(addr_t a, word_t d);
        shadow[a] = d;
    endtask

    function automatic logic [31:0] galois_step(logic [31:0] s);
        return s[0] ? ({1'b0, s[31:1]} ^ 32'ha300_0000) : {1'b0, s[31:1]};
    endfunction

    initial begin
        mem_req_ready   = 1'b0;
        mem_wready      = 1'b0;
        mem_rvalid      = 1'b0;
        mem_rdata       = '0;
        lfsr            = 32'h1e71_60f5;
        rd_line         = '0;
        wr_line         = '0;
        last_read_line  = '0;
        last_write_line = '0;
        rd_count        = 0;
        wr_count        = 0;
        num_reads       = 0;
        num_writes      = 0;
        rd_busy         = 1'b0;
        wr_busy         = 1'b0;
        forever begin
            @(negedge clk);                    // handshakes that finish at the next edge
            if (arst_n) begin
                if (mem_req_valid && mem_req_ready) begin
                    if (mem_req_op == MEM_READ) begin
                        rd_line        = mem_req_addr;
                        last_read_line = mem_req_addr;
                        rd_count       = 0;
                        rd_busy        = 1'b1;
                        num_reads++;
                    end else begin
                        wr_line         = mem_req_addr;
                        last_write_line = mem_req_addr;
                        wr_count        = 0;
                        wr_busy         = 1'b1;
                        num_writes++;
                    end
                end
                if (mem_wvalid && mem_wready) begin
                    store[{wr_line, offset_t'(wr_count)}] = mem_wdata;
                    wb_beats[wr_count] = mem_wdata;
                    wr_count++;
                    wr_busy = (wr_count < WORDS_PER_LINE);
                end
                if (mem_rvalid) begin
                    rd_count++;
                    rd_busy = (rd_count < WORDS_PER_LINE);
                end
            end
            @(posedge clk);
            #1;
            lfsr          = galois_step(lfsr);
            mem_req_ready = arst_n && lfsr[0];
            lfsr          = galois_step(lfsr);
            mem_wready    = wr_busy && lfsr[0];
            lfsr          = galois_step(lfsr);
            mem_rvalid    = rd_busy && lfsr[0];   // gaps between refill beats
            if (mem_rvalid) begin
                mem_rdata = backing_word({rd_line, offset_t'(rd_count)});
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
/*
 * Top level of the 2-way write-back data cache.
 * Ties the controller to the tag and data arrays and the beat counter,
 * and exposes the CPU port and the word-wide memory bus.
 */
`default_nettype none

module dcache_top (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       cpu_valid,
    output logic                      cpu_ready,
    input  wire                       cpu_write,
    input  wire dcache_pkg::addr_t    cpu_addr,
    input  wire dcache_pkg::word_t    cpu_wdata,
    output logic                      rsp_valid,
    output dcache_pkg::word_t         rsp_rdata,
    output logic                      mem_req_valid,
    input  wire                       mem_req_ready,
    output dcache_pkg::mem_op_e       mem_req_op,
    output dcache_pkg::line_addr_t    mem_req_addr,
    output logic                      mem_wvalid,
    input  wire                       mem_wready,
    output dcache_pkg::word_t         mem_wdata,
    input  wire                       mem_rvalid,
    input  wire dcache_pkg::word_t    mem_rdata
);
    import dcache_pkg::*;

    ////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////
    index_t  req_index;
    tag_t    lookup_tag;
    logic    hit;
    logic    hit_way;
    logic    victim_way;
    logic    victim_dirty;
    tag_t    victim_tag;
    logic    tag_we;
    logic    tag_we_way;
    logic    dirty_set;
    logic    lru_touch;
    line_t   rd_line0;
    line_t   rd_line1;
    logic    data_we;
    logic    data_we_way;
    offset_t data_we_offset;
    word_t   data_wdata;
    logic    cnt_start;
    logic    cnt_advance;
    offset_t beat;
    logic    beat_last;

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .cpu_valid      (cpu_valid),
        .cpu_ready      (cpu_ready),
        .cpu_write      (cpu_write),
        .cpu_addr       (cpu_addr),
        .cpu_wdata      (cpu_wdata),
        .rsp_valid      (rsp_valid),
        .rsp_rdata      (rsp_rdata),
        .req_index      (req_index),
        .lookup_tag     (lookup_tag),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .victim_dirty   (victim_dirty),
        .victim_tag     (victim_tag),
        .tag_we         (tag_we),
        .tag_we_way     (tag_we_way),
        .dirty_set      (dirty_set),
        .lru_touch      (lru_touch),
        .rd_line0       (rd_line0),
        .rd_line1       (rd_line1),
        .data_we        (data_we),
        .data_we_way    (data_we_way),
        .data_we_offset (data_we_offset),
        .data_wdata     (data_wdata),
        .cnt_start      (cnt_start),
        .cnt_advance    (cnt_advance),
        .beat           (beat),
        .beat_last      (beat_last),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_op     (mem_req_op),
        .mem_req_addr   (mem_req_addr),
        .mem_wvalid     (mem_wvalid),
        .mem_wready     (mem_wready),
        .mem_wdata      (mem_wdata),
        .mem_rvalid     (mem_rvalid),
        .mem_rdata      (mem_rdata)
    );

    dcache_tag_array u_tag_array (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_index    (req_index),
        .lookup_tag   (lookup_tag),
        .tag_we       (tag_we),
        .tag_we_way   (tag_we_way),
        .dirty_set    (dirty_set),
        .lru_touch    (lru_touch),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_data_array u_data_array (
        .clk            (clk),
        .req_index      (req_index),
        .data_we        (data_we),
        .data_we_way    (data_we_way),
        .data_we_offset (data_we_offset),
        .data_wdata     (data_wdata),
        .rd_line0       (rd_line0),
        .rd_line1       (rd_line1)
    );

    dcache_beat_counter u_beat_counter (
        .clk         (clk),
        .arst_n      (arst_n),
        .cnt_start   (cnt_start),
        .cnt_advance (cnt_advance),
        .beat        (beat),
        .beat_last   (beat_last)
    );

endmodule

`default_nettype wire

//--- hdl/dcache_ctrl.sv
/*
 * Request controller of the data cache. Takes one CPU request at a time,
 * looks it up, and on a miss writes back a dirty victim and refills the
 * line over the word-wide memory bus before completing as a hit.
 */
`default_nettype none

module dcache_ctrl (
    input  wire                       clk,
    input  wire                       arst_n,
    // cpu request and response
    input  wire                       cpu_valid,
    output logic                      cpu_ready,
    input  wire                       cpu_write,
    input  wire dcache_pkg::addr_t    cpu_addr,
    input  wire dcache_pkg::word_t    cpu_wdata,
    output logic                      rsp_valid,
    output dcache_pkg::word_t         rsp_rdata,
    // tag array
    output dcache_pkg::index_t        req_index,
    output dcache_pkg::tag_t          lookup_tag,
    input  wire                       hit,
    input  wire                       hit_way,
    input  wire                       victim_way,
    input  wire                       victim_dirty,
    input  wire dcache_pkg::tag_t     victim_tag,
    output logic                      tag_we,
    output logic                      tag_we_way,
    output logic                      dirty_set,
    output logic                      lru_touch,
    // data array
    input  wire dcache_pkg::line_t    rd_line0,
    input  wire dcache_pkg::line_t    rd_line1,
    output logic                      data_we,
    output logic                      data_we_way,
    output dcache_pkg::offset_t       data_we_offset,
    output dcache_pkg::word_t         data_wdata,
    // beat counter
    output logic                      cnt_start,
    output logic                      cnt_advance,
    input  wire dcache_pkg::offset_t  beat,
    input  wire                       beat_last,
    // memory side
    output logic                      mem_req_valid,
    input  wire                       mem_req_ready,
    output dcache_pkg::mem_op_e       mem_req_op,
    output dcache_pkg::line_addr_t    mem_req_addr,
    output logic                      mem_wvalid,
    input  wire                       mem_wready,
    output dcache_pkg::word_t         mem_wdata,
    input  wire                       mem_rvalid,
    input  wire dcache_pkg::word_t    mem_rdata
);
    import dcache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        write_q;          // latched request
    addr_t       addr_q;
    word_t       wdata_q;
    logic        victim_way_q;     // way being replaced
    word_t       rdata_q;          // last read response
    index_t      index_q;
    offset_t     offset_q;
    line_t       hit_line;
    line_t       victim_line;
    word_t       hit_word;

    assign index_q    = addr_q[OFFSET_W +: INDEX_W];
    assign offset_q   = addr_q[OFFSET_W-1:0];
    assign lookup_tag = addr_q[ADDR_W-1 -: TAG_W];
    assign cpu_ready  = (state_q == ST_IDLE);
    assign req_index  = (state_q == ST_IDLE) ? cpu_addr[OFFSET_W +: INDEX_W] : index_q;

    assign hit_line    = hit_way ? rd_line1 : rd_line0;
    assign hit_word    = hit_line[offset_q*$bits(word_t) +: $bits(word_t)];
    assign victim_line = victim_way_q ? rd_line1 : rd_line0;
    assign mem_wdata   = victim_line[beat*$bits(word_t) +: $bits(word_t)];
    assign rsp_rdata   = (rsp_valid && !write_q) ? hit_word : rdata_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q      <= ST_IDLE;
            victim_way_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_LOOKUP && !hit) begin
                victim_way_q <= victim_way;   // held through write-back and fill
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_valid && cpu_ready) begin
            write_q <= cpu_write;
            addr_q  <= cpu_addr;
            wdata_q <= cpu_wdata;
        end
        if (rsp_valid && !write_q) begin
            rdata_q <= hit_word;
        end
    end

    ////////////////////////////////////////////////////////////
    // next state and per-state outputs
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_d        = state_q;
        rsp_valid      = 1'b0;
        tag_we         = 1'b0;
        tag_we_way     = victim_way_q;
        dirty_set      = 1'b0;
        lru_touch      = 1'b0;
        data_we        = 1'b0;
        data_we_way    = victim_way_q;   // refill default
        data_we_offset = beat;
        data_wdata     = mem_rdata;
        cnt_start      = 1'b0;
        cnt_advance    = 1'b0;
        mem_req_valid  = 1'b0;
        mem_req_op     = MEM_READ;
        mem_req_addr   = {lookup_tag, index_q};
        mem_wvalid     = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (cpu_valid) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    rsp_valid = 1'b1;
                    lru_touch = 1'b1;
                    state_d   = ST_IDLE;
                    if (write_q) begin
                        data_we        = 1'b1;
                        data_we_way    = hit_way;
                        data_we_offset = offset_q;
                        data_wdata     = wdata_q;
                        dirty_set      = 1'b1;
                    end
                end else if (victim_dirty) begin
                    state_d = ST_WB_REQ;
                end else begin
                    state_d = ST_FILL_REQ;
                end
            end
            ST_WB_REQ: begin
                mem_req_valid = 1'b1;
                mem_req_op    = MEM_WRITE;
                mem_req_addr  = {victim_tag, index_q};   // victim's own line
                if (mem_req_ready) begin
                    cnt_start = 1'b1;
                    state_d   = ST_WB_DATA;
                end
            end
            ST_WB_DATA: begin
                mem_wvalid = 1'b1;
                if (mem_wready) begin
                    if (beat_last) begin
                        state_d = ST_FILL_REQ;
                    end else begin
                        cnt_advance = 1'b1;
                    end
                end
            end
            ST_FILL_REQ: begin
                mem_req_valid = 1'b1;
                if (mem_req_ready) begin
                    cnt_start = 1'b1;
                    state_d   = ST_FILL_DATA;
                end
            end
            ST_FILL_DATA: begin
                if (mem_rvalid) begin
                    data_we = 1'b1;
                    if (beat_last) begin
                        tag_we  = 1'b1;           // new tag goes in clean
                        state_d = ST_REREAD;
                    end else begin
                        cnt_advance = 1'b1;
                    end
                end
            end
            ST_REREAD: begin
                state_d = ST_LOOKUP;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // a stalled memory request must not change under the memory's feet
    a_mem_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_req_op) && $stable(mem_req_addr));

    // refill beats only arrive after a read request was taken
    a_rvalid_in_fill: assert property (@(posedge clk) disable iff (!arst_n)
        mem_rvalid |-> state_q == ST_FILL_DATA);

endmodule

`default_nettype wire

//--- hdl/dcache_tag_array.sv
/*
 * Tag store of the 2-way cache with valid, dirty and one LRU bit per set.
 * Reads are registered at req_index; hit and victim are worked out from
 * the registered values against the controller's lookup tag.
 */
`default_nettype none

module dcache_tag_array (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire dcache_pkg::index_t req_index,
    input  wire dcache_pkg::tag_t   lookup_tag,
    input  wire                     tag_we,        // refill done, install lookup_tag
    input  wire                     tag_we_way,
    input  wire                     dirty_set,     // write hit
    input  wire                     lru_touch,
    output logic                    hit,
    output logic                    hit_way,
    output logic                    victim_way,
    output logic                    victim_dirty,
    output dcache_pkg::tag_t        victim_tag
);
    import dcache_pkg::*;

    tag_t                     tag_mem [2][NUM_SETS];
    logic [1:0][NUM_SETS-1:0] valid_q;
    logic [1:0][NUM_SETS-1:0] dirty_q;
    logic [NUM_SETS-1:0]      lru_q;         // least recently used way
    tag_t                     rd_tag [2];
    logic [1:0]               rd_valid;
    logic [1:0]               rd_dirty;
    logic                     rd_lru;
    logic [1:0]               way_hit;

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[tag_we_way][req_index] <= lookup_tag;
        end
        rd_tag[0] <= tag_mem[0][req_index];
        rd_tag[1] <= tag_mem[1][req_index];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            lru_q    <= '0;
            rd_valid <= '0;
            rd_dirty <= '0;
            rd_lru   <= 1'b0;
        end else begin
            rd_valid <= {valid_q[1][req_index], valid_q[0][req_index]};
            rd_dirty <= {dirty_q[1][req_index], dirty_q[0][req_index]};
            rd_lru   <= lru_q[req_index];
            if (tag_we) begin
                valid_q[tag_we_way][req_index] <= 1'b1;
                dirty_q[tag_we_way][req_index] <= 1'b0;
                lru_q[req_index]               <= ~tag_we_way;
            end
            if (lru_touch) begin
                lru_q[req_index] <= ~hit_way;
            end
            if (dirty_set) begin
                dirty_q[hit_way][req_index] <= 1'b1;
            end
        end
    end

    assign way_hit[0] = rd_valid[0] && (rd_tag[0] == lookup_tag);
    assign way_hit[1] = rd_valid[1] && (rd_tag[1] == lookup_tag);
    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];

    // invalid way first, otherwise the lru one
    assign victim_way   = !rd_valid[0] ? 1'b0 : (!rd_valid[1] ? 1'b1 : rd_lru);
    assign victim_dirty = rd_valid[victim_way] && rd_dirty[victim_way];
    assign victim_tag   = rd_tag[victim_way];

    a_one_way_hits: assert property (@(posedge clk) disable iff (!arst_n)
        !(way_hit[0] && way_hit[1]));

endmodule

`default_nettype wire

//--- hdl/dcache_data_array.sv
/*
 * Line storage for both cache ways, 256 lines each.
 * Whole lines are read registered and read-first; writes touch a single
 * word of one way, for write hits and for refill beats alike.
 */
`default_nettype none

module dcache_data_array (
    input  wire                      clk,
    input  wire dcache_pkg::index_t  req_index,
    input  wire                      data_we,
    input  wire                      data_we_way,
    input  wire dcache_pkg::offset_t data_we_offset,
    input  wire dcache_pkg::word_t   data_wdata,
    output dcache_pkg::line_t        rd_line0,
    output dcache_pkg::line_t        rd_line1
);
    import dcache_pkg::*;

    line_t mem [2][NUM_SETS];

    always_ff @(posedge clk) begin
        if (data_we) begin
            mem[data_we_way][req_index][data_we_offset*$bits(word_t) +: $bits(word_t)]
                <= data_wdata;
        end
        rd_line0 <= mem[0][req_index];   // old line on a same-cycle write
        rd_line1 <= mem[1][req_index];
    end

endmodule

`default_nettype wire

//--- hdl/dcache_beat_counter.sv
/*
 * Beat counter for four-word line transfers on the memory bus.
 * Start clears it, advance steps it, beat_last flags the final word.
 */
`default_nettype none

module dcache_beat_counter (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 cnt_start,
    input  wire                 cnt_advance,
    output dcache_pkg::offset_t beat,
    output logic                beat_last
);
    import dcache_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat <= '0;
        end else if (cnt_start) begin
            beat <= '0;
        end else if (cnt_advance) begin
            beat <= beat + 1'b1;
        end
    end

    assign beat_last = (beat == offset_t'(WORDS_PER_LINE - 1));

    // wrapping would silently reuse beat 0 of the same transfer
    a_no_wrap: assert property (@(posedge clk) disable iff (!arst_n)
        cnt_advance && !cnt_start |-> !beat_last);

endmodule

`default_nettype wire

//--- hdl/dcache_pkg.sv
/*
 * Shared geometry, data types and enums for the 2-way data cache.
 * Modules import it inside their body and use scoped names in port lists.
 */
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////
    localparam int ADDR_W         = 30;                // word address
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 2;                 // word within a line
    localparam int WORDS_PER_LINE = 1 << OFFSET_W;
    localparam int LINE_W         = 32 * WORDS_PER_LINE;
    localparam int NUM_SETS       = 1 << INDEX_W;

    ////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////
    typedef logic [31:0]               word_t;
    typedef logic [LINE_W-1:0]         line_t;        // word 0 in the low bits
    typedef logic [ADDR_W-1:0]         addr_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [OFFSET_W-1:0]       offset_t;      // also the beat number
    typedef logic [TAG_W+INDEX_W-1:0]  line_addr_t;   // {tag, index}

    ////////////////////////////////////////////////////////////
    // controller states and memory opcodes
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        ST_IDLE,                                       // waiting for a cpu request
        ST_LOOKUP,                                     // tag compare, hit completes here
        ST_WB_REQ,                                     // write-back request to memory
        ST_WB_DATA,                                    // four victim beats out
        ST_FILL_REQ,                                   // line read request
        ST_FILL_DATA,                                  // four refill beats in
        ST_REREAD                                      // let the arrays show the new line
    } ctrl_state_e;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

endpackage

`default_nettype wire
